/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the sideband master testbench

LOG=sim.log
BIN=Vtb_aib_sb_master

verilator --binary --timing -f tb.f --top-module tb_aib_sb_master -Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* src/aib_sb_master.sv */
// sideband master top: frame timer, shift registers and bring-up FSM on one link interface
`default_nettype none

module aib_sb_master (
  input  wire                         fs_fwd_clk,
  input  wire                         adpt_rstn_sync_fsfwdclk,
  input  wire                         i_conf_done,
  input  wire                         i_tx_dcc_cal_done,
  input  wire                         i_rx_dll_lock,
  input  wire [sb_pkg::EXT_HI_W-1:0]  i_ext_cntl_hi,   // word bits 65:8
  input  wire [sb_pkg::EXT_LO_W-1:0]  i_ext_cntl_lo,   // word bits 4:0
  input  wire                         i_srd,           // partner serial data
  input  wire                         i_srl,           // partner load, bit 0
  output wire                         o_std,
  output wire                         o_stl,
  output wire                         o_tx_dcc_cal_req,
  output wire                         o_rx_dll_lock_req,
  output wire                         o_tx_transfer_en,
  output wire                         o_rx_transfer_en,
  output sb_pkg::sb_word_t            o_sideband       // last word from partner
);

  // ==============================
  // internal link
  // ==============================
  sb_link_if u_link ();

  sb_frame_timer u_sb_frame_timer (
    .fs_fwd_clk              (fs_fwd_clk),
    .adpt_rstn_sync_fsfwdclk (adpt_rstn_sync_fsfwdclk),
    .link                    (u_link)
  );

  sb_shifter u_sb_shifter (
    .fs_fwd_clk              (fs_fwd_clk),
    .adpt_rstn_sync_fsfwdclk (adpt_rstn_sync_fsfwdclk),
    .i_srd                   (i_srd),
    .i_srl                   (i_srl),
    .o_std                   (o_std),
    .o_stl                   (o_stl),
    .link                    (u_link)
  );

  sb_bringup_fsm u_sb_bringup_fsm (
    .fs_fwd_clk              (fs_fwd_clk),
    .adpt_rstn_sync_fsfwdclk (adpt_rstn_sync_fsfwdclk),
    .i_conf_done             (i_conf_done),
    .i_tx_dcc_cal_done       (i_tx_dcc_cal_done),
    .i_rx_dll_lock           (i_rx_dll_lock),
    .i_ext_cntl_hi           (i_ext_cntl_hi),
    .i_ext_cntl_lo           (i_ext_cntl_lo),
    .o_tx_dcc_cal_req        (o_tx_dcc_cal_req),
    .o_rx_dll_lock_req       (o_rx_dll_lock_req),
    .o_tx_transfer_en        (o_tx_transfer_en),
    .o_rx_transfer_en        (o_rx_transfer_en),
    .link                    (u_link)
  );

  assign o_sideband = u_link.rx_word;  // monitor view of the received word

endmodule

`default_nettype wire

/* src/sb_bringup_fsm.sv */
// link bring-up FSM with transmitted word build, calibration and lock requests and transfer enables
`default_nettype none

module sb_bringup_fsm (
  input  wire                         fs_fwd_clk,
  input  wire                         adpt_rstn_sync_fsfwdclk,
  input  wire                         i_conf_done,
  input  wire                         i_tx_dcc_cal_done,
  input  wire                         i_rx_dll_lock,
  input  wire [sb_pkg::EXT_HI_W-1:0]  i_ext_cntl_hi,
  input  wire [sb_pkg::EXT_LO_W-1:0]  i_ext_cntl_lo,
  output logic                        o_tx_dcc_cal_req,
  output logic                        o_rx_dll_lock_req,
  output logic                        o_tx_transfer_en,
  output logic                        o_rx_transfer_en,
  sb_link_if.fsm                      link
);

  import sb_pkg::*;

  sb_state_t state;
  sb_state_t state_nxt;
  logic      rx_valid;  // partner word seen since leaving idle

  // ==============================
  // state register
  // ==============================
  always_ff @(posedge fs_fwd_clk or negedge adpt_rstn_sync_fsfwdclk)
  begin
    if (!adpt_rstn_sync_fsfwdclk)
      state <= SB_IDLE;
    else
      state <= state_nxt;
  end

  // stale partner status from before idle is ignored
  always_ff @(posedge fs_fwd_clk or negedge adpt_rstn_sync_fsfwdclk)
  begin
    if (!adpt_rstn_sync_fsfwdclk)
      rx_valid <= 1'b0;
    else if (state == SB_IDLE)
      rx_valid <= 1'b0;
    else if (link.rx_new)
      rx_valid <= 1'b1;
  end

  always_comb
  begin
    state_nxt = state;
    if (!i_conf_done)
    begin
      state_nxt = SB_IDLE;  // abort from anywhere
    end
    else
    begin
      case (state)
        SB_IDLE:
          state_nxt = SB_OSC;
        SB_OSC:
          if (rx_valid && link.rx_word.f.osc_transfer_en)
            state_nxt = SB_TX_CAL;
        SB_TX_CAL:
          if (i_tx_dcc_cal_done)
            state_nxt = SB_RX_LOCK;
        SB_RX_LOCK:
          if (i_rx_dll_lock && link.rx_word.f.tx_dcc_cal_done)
            state_nxt = SB_TRANSFER;
        SB_TRANSFER:
          state_nxt = SB_TRANSFER;
        default:
          state_nxt = SB_IDLE;
      endcase
    end
  end

  // ==============================
  // outgoing word and controls
  // ==============================
  always_comb
  begin
    link.tx_word                   = '0;  // reserved bits stay zero
    link.tx_word.f.osc_transfer_en = (state != SB_IDLE);
    link.tx_word.f.tx_dcc_cal_done = (state == SB_RX_LOCK) || (state == SB_TRANSFER);
    link.tx_word.f.rx_dll_lock     = (state == SB_TRANSFER);
    link.tx_word.f.tx_transfer_en  = (state == SB_TRANSFER);
    link.tx_word.f.rx_transfer_en  = (state == SB_TRANSFER);
    link.tx_word.f.ext_cntl_hi     = i_ext_cntl_hi;
    link.tx_word.f.ext_cntl_lo     = i_ext_cntl_lo;
  end

  assign o_tx_dcc_cal_req  = (state == SB_TX_CAL);
  assign o_rx_dll_lock_req = (state == SB_RX_LOCK);
  assign o_tx_transfer_en  = (state == SB_TRANSFER);
  assign o_rx_transfer_en  = (state == SB_TRANSFER);

endmodule

`default_nettype wire

/* src/sb_frame_timer.sv */
// sideband frame timer: bit slot counter with first-bit and last-bit strobes
`default_nettype none

module sb_frame_timer (
  input  wire             fs_fwd_clk,
  input  wire             adpt_rstn_sync_fsfwdclk,
  sb_link_if.timer        link
);

  import sb_pkg::*;

  localparam logic [SB_CNT_W-1:0] LAST_SLOT = SB_CNT_W'(SB_LEN - 1);

  logic [SB_CNT_W-1:0] bit_cnt;

  // ==============================
  // free-running slot counter
  // ==============================
  always_ff @(posedge fs_fwd_clk or negedge adpt_rstn_sync_fsfwdclk)
  begin
    if (!adpt_rstn_sync_fsfwdclk)
    begin
      bit_cnt <= '0;  // frame starts right out of reset
    end
    else if (bit_cnt == LAST_SLOT)
    begin
      bit_cnt <= '0;
    end
    else
    begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  assign link.frame_load = (bit_cnt == '0);       // load slot
  assign link.frame_last = (bit_cnt == LAST_SLOT); // bit 0 goes out next

endmodule

`default_nettype wire

/* src/sb_link_if.sv */
// interface for frame strobes and parallel sideband words, with its four modports
`default_nettype none

interface sb_link_if;
  import sb_pkg::*;

  logic     frame_load;  // first bit slot
  logic     frame_last;  // last bit slot
  sb_word_t tx_word;
  sb_word_t rx_word;
  logic     rx_new;      // one cycle per captured word

  modport timer   (output frame_load, output frame_last);

  modport shifter (input  frame_load, input  frame_last, input tx_word,
                   output rx_word,    output rx_new);

  modport fsm     (input  rx_word,    input  rx_new,     output tx_word);

  modport mon     (input  frame_load, input  frame_last, input tx_word,
                   input  rx_word,    input  rx_new);

endinterface

`default_nettype wire

/* src/sb_pkg.sv */
// sideband frame length, counter width, word layout union and bring-up state type
`default_nettype none

package sb_pkg;

  // ==============================
  // frame geometry
  // ==============================
  parameter int SB_LEN   = 81;  // bits per sideband frame
  parameter int SB_CNT_W = 7;   // bit slot counter width

  parameter int EXT_HI_W = 58;  // user control, word bits 65:8
  parameter int EXT_LO_W = 5;   // user control, word bits 4:0

  // ==============================
  // word layout, msb first
  // ==============================
  typedef struct packed {
    logic                osc_transfer_en;  // 80
    logic                rsvd_79;
    logic                tx_transfer_en;   // 78
    logic [1:0]          rsvd_77_76;
    logic                rx_transfer_en;   // 75
    logic                rx_dll_lock;      // 74
    logic [4:0]          rsvd_73_69;
    logic                tx_dcc_cal_done;  // 68
    logic [1:0]          rsvd_67_66;
    logic [EXT_HI_W-1:0] ext_cntl_hi;      // 65:8
    logic [2:0]          rsvd_7_5;
    logic [EXT_LO_W-1:0] ext_cntl_lo;      // 4:0
  } sb_fields_t;

  // shifter sees raw bits, state machine sees fields
  typedef union packed {
    logic [SB_LEN-1:0] raw;
    sb_fields_t        f;
  } sb_word_t;

  // ==============================
  // bring-up sequence
  // ==============================
  typedef enum logic [2:0] {
    SB_IDLE     = 3'd0,
    SB_OSC      = 3'd1,
    SB_TX_CAL   = 3'd2,
    SB_RX_LOCK  = 3'd3,
    SB_TRANSFER = 3'd4
  } sb_state_t;

endpackage

`default_nettype wire

/* src/sb_shifter.sv */
// sideband shift registers: parallel-to-serial transmit and serial-to-parallel receive
`default_nettype none

module sb_shifter (
  input  wire             fs_fwd_clk,
  input  wire             adpt_rstn_sync_fsfwdclk,
  input  wire             i_srd,
  input  wire             i_srl,
  output logic            o_std,
  output logic            o_stl,
  sb_link_if.shifter      link
);

  import sb_pkg::*;

  localparam logic [SB_CNT_W-1:0] FULL_FILL = SB_CNT_W'(SB_LEN - 1);

  logic [SB_LEN-1:0]   tx_sr;
  logic [SB_LEN-2:0]   rx_sr;    // bits 80..1 of the frame in flight
  logic [SB_CNT_W-1:0] rx_fill;  // samples since last load strobe

  // ==============================
  // transmit
  // ==============================
  always_ff @(posedge fs_fwd_clk or negedge adpt_rstn_sync_fsfwdclk)
  begin
    if (!adpt_rstn_sync_fsfwdclk)
    begin
      tx_sr <= '0;
      o_stl <= 1'b0;
    end
    else
    begin
      if (link.frame_load)
        tx_sr <= link.tx_word.raw;           // word sampled once per frame
      else
        tx_sr <= {tx_sr[SB_LEN-2:0], 1'b0};
      o_stl <= link.frame_last;              // lines up with bit 0
    end
  end

  assign o_std = tx_sr[SB_LEN-1];

  // ==============================
  // receive
  // ==============================
  always_ff @(posedge fs_fwd_clk)
  begin
    rx_sr <= {rx_sr[SB_LEN-3:0], i_srd};
  end

  always_ff @(posedge fs_fwd_clk or negedge adpt_rstn_sync_fsfwdclk)
  begin
    if (!adpt_rstn_sync_fsfwdclk)
    begin
      rx_fill      <= '0;
      link.rx_word <= '0;
      link.rx_new  <= 1'b0;
    end
    else
    begin
      link.rx_new <= 1'b0;
      if (i_srl)
      begin
        rx_fill <= '0;
        if (rx_fill == FULL_FILL)  // drop partial frames
        begin
          link.rx_word.raw <= {rx_sr, i_srd};
          link.rx_new      <= 1'b1;
        end
      end
      else if (rx_fill != FULL_FILL)
      begin
        rx_fill <= rx_fill + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* tb.f */
src/sb_pkg.sv
src/sb_link_if.sv
src/sb_frame_timer.sv
src/sb_shifter.sv
src/sb_bringup_fsm.sv
src/aib_sb_master.sv
verification/tb_aib_sb_master.sv

/* verification/tb_aib_sb_master.sv */
// testbench for the sideband master with partner model, directed tests, compare tasks and cycle limit
`default_nettype none

module tb_aib_sb_master;

  import sb_pkg::*;

  localparam int CYCLE_LIMIT  = 40 * SB_LEN;  // 40 frames
  localparam int CTRL_CAL_REQ = 0;
  localparam int CTRL_LCK_REQ = 1;
  localparam int CTRL_TX_XFER = 2;

  logic                fs_fwd_clk;
  logic                adpt_rstn_sync_fsfwdclk;
  logic                i_conf_done;
  logic                i_tx_dcc_cal_done;
  logic                i_rx_dll_lock;
  logic [EXT_HI_W-1:0] i_ext_cntl_hi;
  logic [EXT_LO_W-1:0] i_ext_cntl_lo;
  logic                i_srd;
  logic                i_srl;
  wire                 o_std;
  wire                 o_stl;
  wire                 o_tx_dcc_cal_req;
  wire                 o_rx_dll_lock_req;
  wire                 o_tx_transfer_en;
  wire                 o_rx_transfer_en;
  sb_word_t            o_sideband;

  integer seed        = 93630;
  int     error_count = 0;
  int     tests_run   = 0;
  int     tests_failed = 0;
  int     cycle_count = 0;

  aib_sb_master u_aib_sb_master (
    .fs_fwd_clk              (fs_fwd_clk),
    .adpt_rstn_sync_fsfwdclk (adpt_rstn_sync_fsfwdclk),
    .i_conf_done             (i_conf_done),
    .i_tx_dcc_cal_done       (i_tx_dcc_cal_done),
    .i_rx_dll_lock           (i_rx_dll_lock),
    .i_ext_cntl_hi           (i_ext_cntl_hi),
    .i_ext_cntl_lo           (i_ext_cntl_lo),
    .i_srd                   (i_srd),
    .i_srl                   (i_srl),
    .o_std                   (o_std),
    .o_stl                   (o_stl),
    .o_tx_dcc_cal_req        (o_tx_dcc_cal_req),
    .o_rx_dll_lock_req       (o_rx_dll_lock_req),
    .o_tx_transfer_en        (o_tx_transfer_en),
    .o_rx_transfer_en        (o_rx_transfer_en),
    .o_sideband              (o_sideband)
  );

  initial
  begin
    fs_fwd_clk = 1'b0;
    forever #4 fs_fwd_clk = ~fs_fwd_clk;
  end

  // ==============================
  // run limit
  // ==============================
  always @(posedge fs_fwd_clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("run stopped after %0d cycles, the tests did not finish in time", cycle_count);
      $display("Simulation failed");
      $finish;
    end
  end

  // ==============================
  // compare tasks
  // ==============================
  task automatic check_word(input string name, input sb_word_t got, input sb_word_t exp);
    if (got.raw !== exp.raw)
    begin
      $display("[FAIL] %s got %h expected %h", name, got.raw, exp.raw);
      error_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  // word the master should send per bring-up bit rules
  function automatic sb_word_t build_expected(input logic osc, input logic cal,
                                              input logic xfer);
    sb_word_t w;
    w                   = '0;
    w.f.osc_transfer_en = osc;
    w.f.tx_dcc_cal_done = cal;
    w.f.rx_dll_lock     = xfer;
    w.f.tx_transfer_en  = xfer;
    w.f.rx_transfer_en  = xfer;
    w.f.ext_cntl_hi     = i_ext_cntl_hi;
    w.f.ext_cntl_lo     = i_ext_cntl_lo;
    return w;
  endfunction

  function automatic logic ctrl_value(input int sel);
    case (sel)
      CTRL_CAL_REQ: return o_tx_dcc_cal_req;
      CTRL_LCK_REQ: return o_rx_dll_lock_req;
      default:      return o_tx_transfer_en;
    endcase
  endfunction

  task automatic wait_ctrl(input int sel, input logic val, input int max_cycles,
                           input string name);
    int n;
    n = 0;
    while (ctrl_value(sel) !== val && n < max_cycles)
    begin
      @(negedge fs_fwd_clk);
      n++;
    end
    if (ctrl_value(sel) !== val)
    begin
      $display("%s did not become %0d within %0d cycles", name, val, max_cycles);
      error_count++;
    end
  endtask

  // ==============================
  // partner model
  // ==============================
  task automatic receive_frame(output sb_word_t w);
    logic [SB_LEN-1:0] bits;
    logic              found;
    int                n;
    bits  = '0;
    found = 1'b0;
    n     = 0;
    while (!found && n < 2 * SB_LEN)  // sync to a bit 0 slot
    begin
      @(negedge fs_fwd_clk);
      found = o_stl;
      n++;
    end
    if (!found)
    begin
      $display("no frame strobe seen on o_stl");
      error_count++;
    end
    for (int i = 0; i < SB_LEN; i++)
    begin
      @(negedge fs_fwd_clk);
      bits = {bits[SB_LEN-2:0], o_std};
      if (o_stl !== (i == SB_LEN - 1))
      begin
        $display("o_stl not aligned with bit 0 of the frame");
        error_count++;
      end
    end
    w.raw = bits;
  endtask

  task automatic send_frame(input sb_word_t w);
    logic [SB_LEN-1:0] bits;
    bits = w.raw;
    for (int i = SB_LEN - 1; i >= 0; i--)
    begin
      @(negedge fs_fwd_clk);
      i_srd = bits[SB_LEN-1];  // msb first
      i_srl = (i == 0);
      bits  = {bits[SB_LEN-2:0], 1'b0};
    end
    @(negedge fs_fwd_clk);
    i_srd = 1'b0;
    i_srl = 1'b0;
  endtask

  task automatic randomize_ext_cntl();
    logic [63:0] rnd;
    rnd           = {$random(seed), $random(seed)};
    i_ext_cntl_hi = rnd[EXT_HI_W-1:0];
    i_ext_cntl_lo = rnd[63:64-EXT_LO_W];
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (error_count != errors_before)
    begin
      tests_failed++;
      $display("test %s: FAIL with %0d errors", name, error_count - errors_before);
    end
    else
      $display("test %s: ok", name);
  endtask

  // ==============================
  // directed tests
  // ==============================
  task automatic run_reset_test();
    int e;
    e = error_count;
    check_bit("o_tx_dcc_cal_req", o_tx_dcc_cal_req, 1'b0);
    check_bit("o_rx_dll_lock_req", o_rx_dll_lock_req, 1'b0);
    check_bit("o_tx_transfer_en", o_tx_transfer_en, 1'b0);
    check_bit("o_rx_transfer_en", o_rx_transfer_en, 1'b0);
    check_word("o_sideband", o_sideband, '0);
    finish_test("reset", e);
  endtask

  task automatic run_idle_tx_test();
    sb_word_t got;
    int       e;
    e = error_count;
    randomize_ext_cntl();
    receive_frame(got);
    check_word("idle frame", got, build_expected(1'b0, 1'b0, 1'b0));
    finish_test("idle_tx", e);
  endtask

  task automatic run_rx_capture_test();
    sb_word_t    w;
    logic [95:0] rnd;
    int          e;
    e     = error_count;
    rnd   = {$random(seed), $random(seed), $random(seed)};
    w.raw = rnd[SB_LEN-1:0];
    w.f.osc_transfer_en = 1'b1;  // stale partner status for the osc step
    send_frame(w);
    check_word("o_sideband", o_sideband, w);
    check_bit("o_tx_dcc_cal_req", o_tx_dcc_cal_req, 1'b0);
    finish_test("rx_capture", e);
  endtask

  task automatic run_osc_cal_test();
    sb_word_t got;
    sb_word_t w;
    int       e;
    e = error_count;
    i_conf_done = 1'b1;
    receive_frame(got);
    check_word("osc frame", got, build_expected(1'b1, 1'b0, 1'b0));
    check_bit("o_tx_dcc_cal_req", o_tx_dcc_cal_req, 1'b0);
    w                   = '0;
    w.f.osc_transfer_en = 1'b1;
    send_frame(w);
    wait_ctrl(CTRL_CAL_REQ, 1'b1, 8, "o_tx_dcc_cal_req");
    i_tx_dcc_cal_done = 1'b1;
    wait_ctrl(CTRL_CAL_REQ, 1'b0, 8, "o_tx_dcc_cal_req");
    receive_frame(got);
    check_word("cal frame", got, build_expected(1'b1, 1'b1, 1'b0));
    finish_test("osc_cal", e);
  endtask

  task automatic run_lock_transfer_test();
    sb_word_t got;
    sb_word_t w;
    int       e;
    e = error_count;
    check_bit("o_rx_dll_lock_req", o_rx_dll_lock_req, 1'b1);
    i_rx_dll_lock = 1'b1;
    repeat (4) @(negedge fs_fwd_clk);
    check_bit("o_rx_dll_lock_req", o_rx_dll_lock_req, 1'b1);  // partner not done yet
    check_bit("o_tx_transfer_en", o_tx_transfer_en, 1'b0);
    w                   = '0;
    w.f.osc_transfer_en = 1'b1;
    w.f.tx_dcc_cal_done = 1'b1;
    send_frame(w);
    wait_ctrl(CTRL_TX_XFER, 1'b1, 8, "o_tx_transfer_en");
    check_bit("o_rx_transfer_en", o_rx_transfer_en, 1'b1);
    check_bit("o_rx_dll_lock_req", o_rx_dll_lock_req, 1'b0);
    receive_frame(got);
    check_word("transfer frame", got, build_expected(1'b1, 1'b1, 1'b1));
    finish_test("lock_transfer", e);
  endtask

  task automatic run_return_idle_test();
    sb_word_t got;
    int       e;
    e = error_count;
    i_conf_done       = 1'b0;
    i_tx_dcc_cal_done = 1'b0;
    i_rx_dll_lock     = 1'b0;
    @(negedge fs_fwd_clk);
    check_bit("o_tx_dcc_cal_req", o_tx_dcc_cal_req, 1'b0);
    check_bit("o_rx_dll_lock_req", o_rx_dll_lock_req, 1'b0);
    check_bit("o_tx_transfer_en", o_tx_transfer_en, 1'b0);
    check_bit("o_rx_transfer_en", o_rx_transfer_en, 1'b0);
    randomize_ext_cntl();
    receive_frame(got);
    check_word("idle frame", got, build_expected(1'b0, 1'b0, 1'b0));
    finish_test("return_idle", e);
  endtask

  // ==============================
  // main sequence
  // ==============================
  initial
  begin
    adpt_rstn_sync_fsfwdclk = 1'b0;
    i_conf_done             = 1'b0;
    i_tx_dcc_cal_done       = 1'b0;
    i_rx_dll_lock           = 1'b0;
    i_ext_cntl_hi           = '0;
    i_ext_cntl_lo           = '0;
    i_srd                   = 1'b0;
    i_srl                   = 1'b0;
    repeat (5) @(negedge fs_fwd_clk);
    adpt_rstn_sync_fsfwdclk = 1'b1;
    run_reset_test();
    run_idle_tx_test();
    run_rx_capture_test();
    run_osc_cal_test();
    run_lock_transfer_test();
    run_return_idle_test();
    $display("tests run %0d, tests failed %0d, check errors %0d",
             tests_run, tests_failed, error_count);
    if (error_count == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire
